// ==== common/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

  localparam int xlen = 32;
  localparam int reg_count = 32;
  localparam int reg_addr_width = 5;

  // Major opcodes of the RV32I subset handled by the slice.
  localparam logic [6:0] opcode_lui       = 7'b0110111;
  localparam logic [6:0] opcode_auipc     = 7'b0010111;
  localparam logic [6:0] opcode_jal       = 7'b1101111;
  localparam logic [6:0] opcode_jalr      = 7'b1100111;
  localparam logic [6:0] opcode_branch    = 7'b1100011;
  localparam logic [6:0] opcode_immediate = 7'b0010011;
  localparam logic [6:0] opcode_register  = 7'b0110011;
  localparam logic [6:0] opcode_fence     = 7'b0001111;

  localparam logic [2:0] funct_add  = 3'b000;
  localparam logic [2:0] funct_sll  = 3'b001;
  localparam logic [2:0] funct_slt  = 3'b010;
  localparam logic [2:0] funct_sltu = 3'b011;
  localparam logic [2:0] funct_xor  = 3'b100;
  localparam logic [2:0] funct_srl  = 3'b101;
  localparam logic [2:0] funct_or   = 3'b110;
  localparam logic [2:0] funct_and  = 3'b111;

  localparam logic [2:0] funct_beq  = 3'b000;
  localparam logic [2:0] funct_bne  = 3'b001;
  localparam logic [2:0] funct_blt  = 3'b100;
  localparam logic [2:0] funct_bge  = 3'b101;
  localparam logic [2:0] funct_bltu = 3'b110;
  localparam logic [2:0] funct_bgeu = 3'b111;

  // funct7 values; the alternate one selects SUB and SRA/SRAI.
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  // ADDI x0,x0,0.
  localparam logic [31:0] nop_instr = 32'h0000_0013;

  typedef enum logic [2:0] {
    cls_none,
    cls_alu,
    cls_lui,
    cls_auipc,
    cls_jal,
    cls_jalr,
    cls_branch
  } op_class_type;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_type;

  typedef enum logic [2:0] {
    bcu_beq,
    bcu_bne,
    bcu_blt,
    bcu_bge,
    bcu_bltu,
    bcu_bgeu
  } bcu_op_type;

endpackage

`default_nettype wire

// ==== common/decode_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface decode_if;
  import riscv_pkg::*;

  logic                      valid;
  logic                      illegal;
  op_class_type              op_class;
  alu_op_type                alu_op;
  bcu_op_type                bcu_op;
  logic                      use_imm;
  logic                      wren;
  logic [reg_addr_width-1:0] rd;
  logic [reg_addr_width-1:0] rs1;
  logic [reg_addr_width-1:0] rs2;
  logic [xlen-1:0]           imm;
  logic [xlen-1:0]           pc;

  modport decoder (
    output valid, illegal, op_class, alu_op, bcu_op, use_imm, wren,
    output rd, rs1, rs2, imm, pc
  );

  modport execute (
    input valid, illegal, op_class, alu_op, bcu_op, use_imm, wren,
    input rd, imm, pc
  );

endinterface

`default_nettype wire

// ==== decode/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
  input  logic                       clock,
  input  logic                       arst_n,
  input  logic                       instr_valid,
  input  logic [riscv_pkg::xlen-1:0] instr,
  input  logic [riscv_pkg::xlen-1:0] pc,
  decode_if.decoder                  dec
);
  import riscv_pkg::*;

  logic            valid_q;
  logic [xlen-1:0] instr_q;
  logic [xlen-1:0] pc_q;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;

  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  logic            legal;
  logic            writes_rd;

  // Operation for funct7 == 0; shared by OP and OP-IMM.
  function automatic alu_op_type base_alu_op(input logic [2:0] f3);
    alu_op_type op;
    case (f3)
      funct_add:  op = alu_add;
      funct_sll:  op = alu_sll;
      funct_slt:  op = alu_slt;
      funct_sltu: op = alu_sltu;
      funct_xor:  op = alu_xor;
      funct_srl:  op = alu_srl;
      funct_or:   op = alu_or;
      default:    op = alu_and;
    endcase
    return op;
  endfunction

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= instr_valid;
    end
  end

  always_ff @(posedge clock) begin
    instr_q <= instr;
    pc_q    <= pc;
  end

  assign opcode = instr_q[6:0];
  assign funct3 = instr_q[14:12];
  assign funct7 = instr_q[31:25];

  assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
  assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                  instr_q[11:8], 1'b0};
  assign imm_u = {instr_q[31:12], 12'h000};
  assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                  instr_q[30:21], 1'b0};

  always_comb begin
    dec.op_class = cls_none;
    dec.alu_op   = alu_add;
    dec.bcu_op   = bcu_beq;
    dec.use_imm  = 1'b0;
    dec.imm      = '0;
    writes_rd    = 1'b0;
    legal        = 1'b1;

    case (opcode)
      opcode_lui: begin
        dec.op_class = cls_lui;
        dec.imm      = imm_u;
        writes_rd    = 1'b1;
      end
      opcode_auipc: begin
        dec.op_class = cls_auipc;
        dec.imm      = imm_u;
        writes_rd    = 1'b1;
      end
      opcode_jal: begin
        dec.op_class = cls_jal;
        dec.imm      = imm_j;
        writes_rd    = 1'b1;
      end
      opcode_jalr: begin
        dec.op_class = cls_jalr;
        dec.imm      = imm_i;
        writes_rd    = 1'b1;
        legal        = (funct3 == 3'b000);
      end
      opcode_branch: begin
        dec.op_class = cls_branch;
        dec.imm      = imm_b;
        case (funct3)
          funct_beq:  dec.bcu_op = bcu_beq;
          funct_bne:  dec.bcu_op = bcu_bne;
          funct_blt:  dec.bcu_op = bcu_blt;
          funct_bge:  dec.bcu_op = bcu_bge;
          funct_bltu: dec.bcu_op = bcu_bltu;
          funct_bgeu: dec.bcu_op = bcu_bgeu;
          default:    legal = 1'b0;
        endcase
      end
      opcode_immediate: begin
        dec.op_class = cls_alu;
        dec.use_imm  = 1'b1;
        dec.imm      = imm_i;
        dec.alu_op   = base_alu_op(funct3);
        writes_rd    = 1'b1;
        // Shift immediates carry funct7 in the upper immediate bits.
        if (funct3 == funct_sll && funct7 != funct7_base) begin
          legal = 1'b0;
        end
        if (funct3 == funct_srl) begin
          if (funct7 == funct7_alt) begin
            dec.alu_op = alu_sra;
          end else if (funct7 != funct7_base) begin
            legal = 1'b0;
          end
        end
      end
      opcode_register: begin
        dec.op_class = cls_alu;
        dec.alu_op   = base_alu_op(funct3);
        writes_rd    = 1'b1;
        if (funct7 == funct7_alt) begin
          if (funct3 == funct_add) begin
            dec.alu_op = alu_sub;
          end else if (funct3 == funct_srl) begin
            dec.alu_op = alu_sra;
          end else begin
            legal = 1'b0;
          end
        end else if (funct7 != funct7_base) begin
          legal = 1'b0;
        end
      end
      opcode_fence: begin
        legal = (funct3 == 3'b000);
      end
      default: begin
        legal = 1'b0;
      end
    endcase

    if (!legal || instr_q == nop_instr) begin
      dec.op_class = cls_none;
      writes_rd    = 1'b0;
    end
  end

  assign dec.valid   = valid_q;
  assign dec.illegal = valid_q & ~legal;
  assign dec.wren    = valid_q & writes_rd & (instr_q[11:7] != '0);
  assign dec.rd      = instr_q[11:7];
  assign dec.rs1     = instr_q[19:15];
  assign dec.rs2     = instr_q[24:20];
  assign dec.pc      = pc_q;

  // The rd field of the word taken at the previous edge is never x0 when writing.
  a_wren_not_x0: assert property (@(posedge clock) disable iff (!arst_n)
    dec.wren |-> $past(instr[11:7]) != '0);

  a_illegal_no_write: assert property (@(posedge clock) disable iff (!arst_n)
    !(dec.illegal && dec.wren));

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file (
  input  logic                                 clock,
  input  logic                                 arst_n,
  input  logic [riscv_pkg::reg_addr_width-1:0] rs1,
  input  logic [riscv_pkg::reg_addr_width-1:0] rs2,
  output logic [riscv_pkg::xlen-1:0]           rs1_data,
  output logic [riscv_pkg::xlen-1:0]           rs2_data,
  input  logic                                 wr_en,
  input  logic [riscv_pkg::reg_addr_width-1:0] wr_addr,
  input  logic [riscv_pkg::xlen-1:0]           wr_data
);
  import riscv_pkg::*;

  // x0 is not stored.
  logic [xlen-1:0] regs [1:reg_count-1];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // The decoder is expected to drop writes to x0 before they get here.
  a_no_x0_write: assert property (@(posedge clock) disable iff (!arst_n)
    !(wr_en && wr_addr == '0));

endmodule

`default_nettype wire

// ==== source/int_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module int_alu (
  input  logic                                 clock,
  input  logic                                 arst_n,
  decode_if.execute                            dec,
  input  logic [riscv_pkg::xlen-1:0]           rs1_data,
  input  logic [riscv_pkg::xlen-1:0]           rs2_data,
  output logic                                 wr_en,
  output logic [riscv_pkg::reg_addr_width-1:0] wr_addr,
  output logic [riscv_pkg::xlen-1:0]           wr_data,
  output logic                                 wb_valid,
  output logic [riscv_pkg::reg_addr_width-1:0] wb_addr,
  output logic [riscv_pkg::xlen-1:0]           wb_data,
  output logic                                 redirect,
  output logic [riscv_pkg::xlen-1:0]           redirect_pc,
  output logic                                 illegal
);
  import riscv_pkg::*;

  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] result;
  logic [xlen-1:0] jalr_sum;
  logic [xlen-1:0] target;
  logic            taken;
  logic            redirect_d;

  assign op_b     = dec.use_imm ? dec.imm : rs2_data;
  assign jalr_sum = rs1_data + dec.imm;

  always_comb begin
    case (dec.alu_op)
      alu_add:  alu_res = rs1_data + op_b;
      alu_sub:  alu_res = rs1_data - op_b;
      alu_sll:  alu_res = rs1_data << op_b[4:0];
      alu_slt:  alu_res = {{(xlen-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
      alu_sltu: alu_res = {{(xlen-1){1'b0}}, rs1_data < op_b};
      alu_xor:  alu_res = rs1_data ^ op_b;
      alu_srl:  alu_res = rs1_data >> op_b[4:0];
      alu_sra:  alu_res = $unsigned($signed(rs1_data) >>> op_b[4:0]);
      alu_or:   alu_res = rs1_data | op_b;
      default:  alu_res = rs1_data & op_b;
    endcase
  end

  // Branches always compare the two register operands.
  always_comb begin
    case (dec.bcu_op)
      bcu_beq:  taken = (rs1_data == rs2_data);
      bcu_bne:  taken = (rs1_data != rs2_data);
      bcu_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
      bcu_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      bcu_bltu: taken = (rs1_data < rs2_data);
      default:  taken = (rs1_data >= rs2_data);
    endcase
  end

  always_comb begin
    result     = '0;
    redirect_d = 1'b0;
    target     = dec.pc + dec.imm;
    case (dec.op_class)
      cls_alu:   result = alu_res;
      cls_lui:   result = dec.imm;
      cls_auipc: result = dec.pc + dec.imm;
      cls_jal: begin
        result     = dec.pc + 32'd4;
        redirect_d = 1'b1;
      end
      cls_jalr: begin
        result     = dec.pc + 32'd4;
        redirect_d = 1'b1;
        target     = {jalr_sum[xlen-1:1], 1'b0};
      end
      cls_branch: redirect_d = taken;
      default:    result = '0;
    endcase
  end

  // The register file takes the result at the same edge as the outputs.
  assign wr_en   = dec.wren;
  assign wr_addr = dec.rd;
  assign wr_data = result;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid <= 1'b0;
      redirect <= 1'b0;
      illegal  <= 1'b0;
    end else begin
      wb_valid <= dec.wren;
      redirect <= dec.valid & redirect_d;
      illegal  <= dec.illegal;
    end
  end

  always_ff @(posedge clock) begin
    wb_addr     <= dec.rd;
    wb_data     <= result;
    redirect_pc <= target;
  end

  a_redirect_not_illegal: assert property (@(posedge clock) disable iff (!arst_n)
    !(redirect && illegal));

endmodule

`default_nettype wire

// ==== source/exec_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_core (
  input  logic                                 clock,
  input  logic                                 arst_n,
  input  logic                                 instr_valid,
  input  logic [riscv_pkg::xlen-1:0]           instr,
  input  logic [riscv_pkg::xlen-1:0]           pc,
  output logic                                 wb_valid,
  output logic [riscv_pkg::reg_addr_width-1:0] wb_addr,
  output logic [riscv_pkg::xlen-1:0]           wb_data,
  output logic                                 redirect,
  output logic [riscv_pkg::xlen-1:0]           redirect_pc,
  output logic                                 illegal
);
  import riscv_pkg::*;

  logic [xlen-1:0]           rs1_data;
  logic [xlen-1:0]           rs2_data;
  logic                      rf_wr_en;
  logic [reg_addr_width-1:0] rf_wr_addr;
  logic [xlen-1:0]           rf_wr_data;

  decode_if dec_bus ();

  instr_decoder decoder0 (
    .clock       (clock),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .dec         (dec_bus.decoder)
  );

  register_file regfile0 (
    .clock    (clock),
    .arst_n   (arst_n),
    .rs1      (dec_bus.rs1),
    .rs2      (dec_bus.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (rf_wr_en),
    .wr_addr  (rf_wr_addr),
    .wr_data  (rf_wr_data)
  );

  int_alu alu0 (
    .clock       (clock),
    .arst_n      (arst_n),
    .dec         (dec_bus.execute),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .wr_en       (rf_wr_en),
    .wr_addr     (rf_wr_addr),
    .wr_data     (rf_wr_data),
    .wb_valid    (wb_valid),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .illegal     (illegal)
  );

endmodule

`default_nettype wire

// ==== sim/exec_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_core_tb;
  import riscv_pkg::*;

  localparam int clk_period  = 100;
  localparam int drive_delay = 5;
  localparam int num_tests   = 2000;
  localparam int timeout_ns  = (num_tests + 50) * clk_period;

  typedef struct packed {
    int          idx;
    logic        wb_valid;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        illegal;
  } outcome_type;

  logic        clock;
  logic        arst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        wb_valid;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic        illegal;

  integer      seed;
  int          errors;
  logic [31:0] model_regs [0:31];
  logic [4:0]  last_rd;
  outcome_type pending [$];

  exec_core dut0 (
    .clock       (clock),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .wb_valid    (wb_valid),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .illegal     (illegal)
  );

  initial begin
    clock = 1'b0;
    forever #(clk_period / 2) clock = ~clock;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors = errors + 1;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b011:  return {31'd0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // Mostly x0..x7, and often the previous destination, so that operands depend on each other.
  task automatic pick_reg(output logic [4:0] r);
    logic [31:0] w;
    w = $random(seed);
    r = w[4:0];
    if (w[9:8] == 2'b00) begin
      r = last_rd;
    end else if (w[9:8] != 2'b11) begin
      r[4:3] = 2'b00;
    end
  endtask

  task automatic make_instr(output logic [31:0] ins);
    logic [31:0] w;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    int          kind;
    int          sel;
    w = $random(seed);
    kind = int'($unsigned($random(seed)) % 100);
    sel = int'($unsigned($random(seed)) % 6);
    pick_reg(rd);
    pick_reg(rs1);
    pick_reg(rs2);
    f3 = w[14:12];
    if (kind < 20) begin
      ins = {w[31:20], rs1, 3'b000, rd, opcode_immediate};
    end else if (kind < 35) begin
      ins = {w[31:20], rs1, f3, rd, opcode_immediate};
      if (f3 == 3'b001 || f3 == 3'b101) begin
        ins[31:25] = (f3 == 3'b101 && w[0]) ? 7'b0100000 : 7'b0000000;
      end
    end else if (kind < 55) begin
      ins = {7'b0000000, rs2, rs1, f3, rd, opcode_register};
      if ((f3 == 3'b000 || f3 == 3'b101) && w[1]) begin
        ins[31:25] = 7'b0100000;
      end
    end else if (kind < 62) begin
      ins = {w[31:12], rd, (w[2] ? opcode_lui : opcode_auipc)};
    end else if (kind < 68) begin
      ins = {w[31:12], rd, opcode_jal};
    end else if (kind < 73) begin
      ins = {w[31:20], rs1, 3'b000, rd, opcode_jalr};
    end else if (kind < 85) begin
      // Branch funct3 values are 0, 1 and 4 to 7.
      f3 = (sel < 2) ? 3'(sel) : 3'(sel + 2);
      if (w[3]) begin
        rs2 = rs1;
      end
      ins = {w[31:25], rs2, rs1, f3, w[11:7], opcode_branch};
    end else if (kind < 90) begin
      ins = w[4] ? nop_instr : {w[31:20], 5'd0, 3'b000, 5'd0, opcode_fence};
    end else begin
      case (sel)
        0:       ins = {w[31:20], rs1, f3, rd, 7'b0000011};
        1:       ins = {w[31:25], rs2, rs1, f3, w[11:7], 7'b0100011};
        2:       ins = {w[31:7], 7'b1110011};
        3:       ins = {7'b0000001, rs2, rs1, f3, rd, opcode_register};
        default: ins = w;
      endcase
    end
    last_rd = ins[11:7];
  endtask

  // Architectural model of one instruction, applied in issue order.
  task automatic model_step(input int idx, input logic valid, input logic [31:0] ins,
                            input logic [31:0] pc_in, output outcome_type e);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] res;
    logic        legal;
    logic        writes;
    f3 = ins[14:12];
    f7 = ins[31:25];
    a = model_regs[ins[19:15]];
    b = model_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    e = '0;
    e.idx = idx;
    legal = 1'b1;
    writes = 1'b1;
    res = '0;
    case (ins[6:0])
      opcode_lui:   res = {ins[31:12], 12'h000};
      opcode_auipc: res = pc_in + {ins[31:12], 12'h000};
      opcode_jal: begin
        res = pc_in + 32'd4;
        e.redirect = 1'b1;
        e.redirect_pc = pc_in + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      opcode_jalr: begin
        legal = (f3 == 3'b000);
        res = pc_in + 32'd4;
        e.redirect = 1'b1;
        e.redirect_pc = (a + imm_i) & 32'hffff_fffe;
      end
      opcode_branch: begin
        writes = 1'b0;
        e.redirect_pc = pc_in + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        case (f3)
          3'b000:  e.redirect = (a == b);
          3'b001:  e.redirect = (a != b);
          3'b100:  e.redirect = ($signed(a) < $signed(b));
          3'b101:  e.redirect = ($signed(a) >= $signed(b));
          3'b110:  e.redirect = (a < b);
          3'b111:  e.redirect = (a >= b);
          default: legal = 1'b0;
        endcase
      end
      opcode_immediate: begin
        if (f3 == 3'b001 && f7 != 7'h00) begin
          legal = 1'b0;
        end
        if (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20) begin
          legal = 1'b0;
        end
        res = alu_calc(f3, f3 == 3'b101 && f7 == 7'h20, a, imm_i);
      end
      opcode_register: begin
        legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        res = alu_calc(f3, f7 == 7'h20, a, b);
      end
      opcode_fence: begin
        writes = 1'b0;
        legal = (f3 == 3'b000);
      end
      default: legal = 1'b0;
    endcase
    e.illegal = valid && !legal;
    e.redirect = valid && legal && e.redirect;
    e.wb_valid = valid && legal && writes && ins[11:7] != 5'd0;
    e.wb_addr = ins[11:7];
    e.wb_data = res;
    if (e.wb_valid) begin
      model_regs[ins[11:7]] = res;
    end
  endtask

  task automatic check_outcome(input outcome_type e);
    string tag;
    tag = $sformatf("instr %0d", e.idx);
    check_value({tag, " wb_valid"}, 32'(e.wb_valid), 32'(wb_valid));
    check_value({tag, " redirect"}, 32'(e.redirect), 32'(redirect));
    check_value({tag, " illegal"}, 32'(e.illegal), 32'(illegal));
    if (e.wb_valid) begin
      check_value({tag, " wb_addr"}, 32'(e.wb_addr), 32'(wb_addr));
      check_value({tag, " wb_data"}, e.wb_data, wb_data);
    end
    if (e.redirect) begin
      check_value({tag, " redirect_pc"}, e.redirect_pc, redirect_pc);
    end
  endtask

  initial begin
    #(timeout_ns);
    $display("Timeout after %0d ns, the instruction stream did not complete", timeout_ns);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    outcome_type e;
    logic [31:0] ins;
    logic [31:0] w;
    logic        valid_next;
    seed = 32'h9610;
    errors = 0;
    last_rd = '0;
    arst_n = 1'b0;
    instr_valid = 1'b0;
    instr = nop_instr;
    pc = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (2) @(posedge clock);
    #(drive_delay);
    arst_n = 1'b1;
    // The two result slots right after reset must be idle.
    e = '0;
    e.idx = -1;
    pending.push_back(e);
    pending.push_back(e);
    for (int n = 0; n < num_tests + 2; n++) begin
      @(posedge clock);
      #(drive_delay);
      e = pending.pop_front();
      check_outcome(e);
      w = $random(seed);
      make_instr(ins);
      valid_next = (n < num_tests) && (w[3:0] != 4'd0);
      model_step(n, valid_next, ins, {w[31:2], 2'b00}, e);
      pending.push_back(e);
      instr_valid = valid_next;
      instr = ins;
      pc = {w[31:2], 2'b00};
    end
    $display("Run complete: %0d instructions, %0d errors", num_tests, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/riscv_pkg.sv
common/decode_if.sv
decode/instr_decoder.sv
source/register_file.sv
source/int_alu.sv
source/exec_core.sv
sim/exec_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f \
  --top-module exec_core_tb -o exec_core_sim

output=$(./obj_dir/exec_core_sim)
echo "$output"

if echo "$output" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
